/* rtl/armPkg.sv */
package armPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 4;

	// r15 reads as the address of the current instruction plus 8
	localparam logic [RegAddrWidth-1:0] PcReg = 4'd15;

	// instruction bits 27:26
	typedef enum logic [1:0] {
		classData = 2'b00,
		classMem = 2'b01,
		classBranch = 2'b10
	} instrClassT;

	typedef enum logic [3:0] {
		opAnd = 4'h0,
		opSub = 4'h2,
		opAdd = 4'h4,
		opCmp = 4'ha,
		opOrr = 4'hc,
		opMov = 4'hd
	} aluOpT;

	typedef enum logic [3:0] {
		condEq = 4'h0,
		condNe = 4'h1,
		condCs = 4'h2,
		condCc = 4'h3,
		condMi = 4'h4,
		condPl = 4'h5,
		condVs = 4'h6,
		condVc = 4'h7,
		condHi = 4'h8,
		condLs = 4'h9,
		condGe = 4'ha,
		condLt = 4'hb,
		condGt = 4'hc,
		condLe = 4'hd,
		condAl = 4'he
	} condT;

	// N, Z, C, V from msb down
	typedef logic [3:0] flagsT;

	localparam int FlagN = 3;
	localparam int FlagZ = 2;
	localparam int FlagC = 1;
	localparam int FlagV = 0;

	// instruction fields
	localparam int CondLsb = 28;
	localparam int ClassLsb = 26;
	localparam int ImmBit = 25;
	localparam int OpLsb = 21;
	localparam int UpBit = 23;
	localparam int SBit = 20;
	localparam int LoadBit = 20;
	localparam int RnLsb = 16;
	localparam int RdLsb = 12;
	localparam int RmLsb = 0;
	localparam int Imm8Width = 8;
	localparam int Imm12Width = 12;
	localparam int BrOffWidth = 24;

endpackage

/* rtl/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [armPkg::RegAddrWidth-1:0]  i_rdAddr1,
	input  logic [armPkg::RegAddrWidth-1:0]  i_rdAddr2,
	output logic [armPkg::DataWidth-1:0]     o_rdData1,
	output logic [armPkg::DataWidth-1:0]     o_rdData2,
	input  logic [armPkg::RegAddrWidth-1:0]  i_wrAddr,
	input  logic [armPkg::DataWidth-1:0]     i_wrData,
	input  logic                             i_wrEnable
);

	localparam int NumRegs = 2 ** armPkg::RegAddrWidth;

	logic [armPkg::DataWidth-1:0] regs [NumRegs];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wrEnable) begin
			regs[i_wrAddr] <= i_wrData;
		end
	end

	// no write-through, a write is visible the cycle after
	assign o_rdData1 = regs[i_rdAddr1];
	assign o_rdData2 = regs[i_rdAddr2];

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
	input  logic [armPkg::RegAddrWidth-1:0]  i_rdAddr1,
	input  logic [armPkg::RegAddrWidth-1:0]  i_rdAddr2,
	input  logic                             i_use1,
	input  logic                             i_use2,
	input  logic [armPkg::RegAddrWidth-1:0]  i_destE,
	input  logic                             i_regWriteE,
	input  logic [armPkg::RegAddrWidth-1:0]  i_destM,
	input  logic                             i_regWriteM,
	input  logic [armPkg::RegAddrWidth-1:0]  i_destW,
	input  logic                             i_regWriteW,
	input  logic                             i_branchTaken,
	output logic                             o_stallDecode,
	output logic                             o_flushDecode
);

	logic pending1;
	logic pending2;

	// true while an older instruction still has to write addr
	function automatic logic isPending(
		logic [armPkg::RegAddrWidth-1:0] addr,
		logic [armPkg::RegAddrWidth-1:0] destE,
		logic weE,
		logic [armPkg::RegAddrWidth-1:0] destM,
		logic weM,
		logic [armPkg::RegAddrWidth-1:0] destW,
		logic weW
	);
		return (weE && (addr == destE)) ||
			(weM && (addr == destM)) ||
			(weW && (addr == destW));
	endfunction

	assign pending1 = i_use1 && isPending(i_rdAddr1, i_destE, i_regWriteE,
		i_destM, i_regWriteM, i_destW, i_regWriteW);
	assign pending2 = i_use2 && isPending(i_rdAddr2, i_destE, i_regWriteE,
		i_destM, i_regWriteM, i_destW, i_regWriteW);

	// the flushed instruction no longer needs its operands
	assign o_stallDecode = (pending1 || pending2) && !i_branchTaken;
	assign o_flushDecode = i_branchTaken;

endmodule

/* rtl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [armPkg::DataWidth-1:0]     i_inst,
	input  logic [armPkg::DataWidth-1:0]     i_pc,
	input  logic                             i_stall,
	input  logic                             i_flush,
	input  logic [armPkg::DataWidth-1:0]     i_rdData1,
	input  logic [armPkg::DataWidth-1:0]     i_rdData2,
	output logic [armPkg::RegAddrWidth-1:0]  o_rdAddr1,
	output logic [armPkg::RegAddrWidth-1:0]  o_rdAddr2,
	output logic                             o_use1,
	output logic                             o_use2,
	output logic [armPkg::DataWidth-1:0]     o_pcPlus8E,
	output logic [armPkg::DataWidth-1:0]     o_operandAE,
	output logic [armPkg::DataWidth-1:0]     o_operandBE,
	output logic [armPkg::DataWidth-1:0]     o_storeDataE,
	output logic [armPkg::DataWidth-1:0]     o_immE,
	output logic                             o_useImmE,
	output armPkg::aluOpT                    o_aluOpE,
	output armPkg::instrClassT               o_classE,
	output armPkg::condT                     o_condE,
	output logic                             o_setFlagsE,
	output logic                             o_upE,
	output logic                             o_regWriteE,
	output logic                             o_memWriteE,
	output logic                             o_memReadE,
	output logic [armPkg::RegAddrWidth-1:0]  o_destE
);

	localparam int Dw = armPkg::DataWidth;

	logic [Dw-1:0] instD;
	logic [Dw-1:0] pcD;
	logic validD;
	logic [Dw-1:0] pcPlus8D;
	logic [Dw-1:0] read1D;
	logic [Dw-1:0] read2D;
	logic [Dw-1:0] immD;
	armPkg::instrClassT classD;
	armPkg::aluOpT opD;
	armPkg::aluOpT aluOpD;
	logic use1D;
	logic use2D;
	logic useImmD;
	logic setFlagsD;
	logic regWriteD;
	logic memWriteD;
	logic memReadD;
	logic loadBubble;

	// if/id
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			validD <= 1'b0;
		end else if (i_flush) begin
			validD <= 1'b0;
		end else if (!i_stall) begin
			validD <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_flush || !i_stall) begin
			instD <= i_inst;
			pcD <= i_pc;
		end
	end

	always_comb begin
		classD = armPkg::instrClassT'(instD[armPkg::ClassLsb +: 2]);
		opD = armPkg::aluOpT'(instD[armPkg::OpLsb +: 4]);
		o_rdAddr1 = instD[armPkg::RnLsb +: armPkg::RegAddrWidth];
		o_rdAddr2 = instD[armPkg::RmLsb +: armPkg::RegAddrWidth];
		use1D = 1'b0;
		use2D = 1'b0;
		immD = '0;
		useImmD = 1'b0;
		aluOpD = armPkg::opAdd;
		setFlagsD = 1'b0;
		regWriteD = 1'b0;
		memWriteD = 1'b0;
		memReadD = 1'b0;
		case (classD)
			armPkg::classData: begin
				use1D = (opD != armPkg::opMov);
				use2D = !instD[armPkg::ImmBit];
				immD = {{(Dw - armPkg::Imm8Width){1'b0}}, instD[armPkg::Imm8Width-1:0]};
				useImmD = instD[armPkg::ImmBit];
				aluOpD = opD;
				setFlagsD = instD[armPkg::SBit];
				regWriteD = (opD != armPkg::opCmp);
			end
			armPkg::classMem: begin
				// second port reads rd, the store data
				o_rdAddr2 = instD[armPkg::RdLsb +: armPkg::RegAddrWidth];
				use1D = 1'b1;
				use2D = !instD[armPkg::LoadBit];
				immD = {{(Dw - armPkg::Imm12Width){1'b0}}, instD[armPkg::Imm12Width-1:0]};
				useImmD = 1'b1;
				regWriteD = instD[armPkg::LoadBit];
				memReadD = instD[armPkg::LoadBit];
				memWriteD = !instD[armPkg::LoadBit];
			end
			armPkg::classBranch: begin
				// word offset, already scaled by 4
				immD = {{(Dw - armPkg::BrOffWidth - 2){instD[armPkg::BrOffWidth-1]}},
					instD[armPkg::BrOffWidth-1:0], 2'b00};
			end
			default: begin
			end
		endcase
	end

	assign o_use1 = use1D && validD;
	assign o_use2 = use2D && validD;

	assign pcPlus8D = pcD + 8;
	assign read1D = (o_rdAddr1 == armPkg::PcReg) ? pcPlus8D : i_rdData1;
	assign read2D = (o_rdAddr2 == armPkg::PcReg) ? pcPlus8D : i_rdData2;

	assign loadBubble = i_stall || i_flush || !validD;

	// id/ex
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_classE <= armPkg::classData;
			o_setFlagsE <= 1'b0;
			o_regWriteE <= 1'b0;
			o_memWriteE <= 1'b0;
			o_memReadE <= 1'b0;
		end else begin
			o_classE <= loadBubble ? armPkg::classData : classD;
			o_setFlagsE <= setFlagsD && !loadBubble;
			o_regWriteE <= regWriteD && !loadBubble;
			o_memWriteE <= memWriteD && !loadBubble;
			o_memReadE <= memReadD && !loadBubble;
		end
	end

	always_ff @(posedge clk) begin
		o_pcPlus8E <= pcPlus8D;
		o_operandAE <= read1D;
		o_operandBE <= read2D;
		o_storeDataE <= read2D;
		o_immE <= immD;
		o_useImmE <= useImmD;
		o_aluOpE <= aluOpD;
		o_condE <= armPkg::condT'(instD[armPkg::CondLsb +: 4]);
		o_upE <= instD[armPkg::UpBit];
		o_destE <= instD[armPkg::RdLsb +: armPkg::RegAddrWidth];
	end

endmodule

/* rtl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [armPkg::DataWidth-1:0]     i_pcPlus8E,
	input  logic [armPkg::DataWidth-1:0]     i_operandAE,
	input  logic [armPkg::DataWidth-1:0]     i_operandBE,
	input  logic [armPkg::DataWidth-1:0]     i_storeDataE,
	input  logic [armPkg::DataWidth-1:0]     i_immE,
	input  logic                             i_useImmE,
	input  armPkg::aluOpT                    i_aluOpE,
	input  armPkg::instrClassT               i_classE,
	input  armPkg::condT                     i_condE,
	input  logic                             i_setFlagsE,
	input  logic                             i_upE,
	input  logic                             i_regWriteE,
	input  logic                             i_memWriteE,
	input  logic                             i_memReadE,
	input  logic [armPkg::RegAddrWidth-1:0]  i_destE,
	output logic                             o_branchTaken,
	output logic [armPkg::DataWidth-1:0]     o_branchTarget,
	output logic                             o_regWriteE,
	output logic [armPkg::RegAddrWidth-1:0]  o_destE,
	output logic [armPkg::DataWidth-1:0]     o_aluOutM,
	output logic [armPkg::DataWidth-1:0]     o_storeDataM,
	output logic [armPkg::RegAddrWidth-1:0]  o_destM,
	output logic                             o_regWriteM,
	output logic                             o_memWriteM,
	output logic                             o_memReadM,
	output logic                             o_memToRegM
);

	localparam int Msb = armPkg::DataWidth - 1;

	armPkg::flagsT flagsQ;
	armPkg::flagsT aluFlags;
	logic [armPkg::DataWidth-1:0] srcB;
	logic [armPkg::DataWidth:0] wideSum;
	logic [armPkg::DataWidth-1:0] aluResult;
	logic [armPkg::DataWidth-1:0] memAddr;
	logic [armPkg::DataWidth-1:0] resultE;
	logic condPass;

	function automatic logic condHolds(armPkg::condT cond, armPkg::flagsT flags);
		logic n;
		logic z;
		logic c;
		logic v;
		n = flags[armPkg::FlagN];
		z = flags[armPkg::FlagZ];
		c = flags[armPkg::FlagC];
		v = flags[armPkg::FlagV];
		case (cond)
			armPkg::condEq: return z;
			armPkg::condNe: return !z;
			armPkg::condCs: return c;
			armPkg::condCc: return !c;
			armPkg::condMi: return n;
			armPkg::condPl: return !n;
			armPkg::condVs: return v;
			armPkg::condVc: return !v;
			armPkg::condHi: return c && !z;
			armPkg::condLs: return !c || z;
			armPkg::condGe: return n == v;
			armPkg::condLt: return n != v;
			armPkg::condGt: return !z && (n == v);
			armPkg::condLe: return z || (n != v);
			armPkg::condAl: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	always_comb begin
		srcB = i_useImmE ? i_immE : i_operandBE;
		wideSum = '0;
		aluFlags = flagsQ;
		case (i_aluOpE)
			armPkg::opAnd: aluResult = i_operandAE & srcB;
			armPkg::opOrr: aluResult = i_operandAE | srcB;
			armPkg::opAdd: begin
				wideSum = {1'b0, i_operandAE} + {1'b0, srcB};
				aluResult = wideSum[Msb:0];
				aluFlags[armPkg::FlagC] = wideSum[Msb+1];
				aluFlags[armPkg::FlagV] = (i_operandAE[Msb] == srcB[Msb]) &&
					(aluResult[Msb] != i_operandAE[Msb]);
			end
			armPkg::opSub, armPkg::opCmp: begin
				// carry set means no borrow
				wideSum = {1'b0, i_operandAE} + {1'b0, ~srcB} + 1'b1;
				aluResult = wideSum[Msb:0];
				aluFlags[armPkg::FlagC] = wideSum[Msb+1];
				aluFlags[armPkg::FlagV] = (i_operandAE[Msb] != srcB[Msb]) &&
					(aluResult[Msb] != i_operandAE[Msb]);
			end
			default: aluResult = srcB;
		endcase
		aluFlags[armPkg::FlagN] = aluResult[Msb];
		aluFlags[armPkg::FlagZ] = (aluResult == '0);
	end

	assign memAddr = i_upE ? i_operandAE + i_immE : i_operandAE - i_immE;
	assign resultE = (i_classE == armPkg::classMem) ? memAddr : aluResult;

	assign condPass = condHolds(i_condE, flagsQ);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flagsQ <= '0;
		end else if (condPass && i_setFlagsE) begin
			flagsQ <= aluFlags;
		end
	end

	assign o_branchTaken = condPass && (i_classE == armPkg::classBranch);
	assign o_branchTarget = i_pcPlus8E + i_immE;
	assign o_regWriteE = i_regWriteE && condPass;
	assign o_destE = i_destE;

	// ex/mem, a failed condition leaves a bubble
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_regWriteM <= 1'b0;
			o_memWriteM <= 1'b0;
			o_memReadM <= 1'b0;
			o_memToRegM <= 1'b0;
		end else begin
			o_regWriteM <= i_regWriteE && condPass;
			o_memWriteM <= i_memWriteE && condPass;
			o_memReadM <= i_memReadE && condPass;
			o_memToRegM <= i_memReadE && condPass;
		end
	end

	always_ff @(posedge clk) begin
		o_aluOutM <= resultE;
		o_storeDataM <= i_storeDataE;
		o_destM <= i_destE;
	end

endmodule

/* rtl/armCore.sv */
`timescale 1ns/1ps

module armCore #(
	parameter logic [armPkg::DataWidth-1:0] ResetPc = '0
) (
	input  logic                          clk,
	input  logic                          reset,
	output logic [armPkg::DataWidth-1:0]  o_pc,
	input  logic [armPkg::DataWidth-1:0]  i_inst,
	output logic [armPkg::DataWidth-1:0]  o_memAddr,
	output logic                          o_memWrite,
	output logic                          o_memRead,
	output logic [armPkg::DataWidth-1:0]  o_writeData,
	input  logic [armPkg::DataWidth-1:0]  i_readData
);

	logic [armPkg::RegAddrWidth-1:0] rdAddr1;
	logic [armPkg::RegAddrWidth-1:0] rdAddr2;
	logic [armPkg::DataWidth-1:0] rdData1;
	logic [armPkg::DataWidth-1:0] rdData2;
	logic use1;
	logic use2;
	logic stallDecode;
	logic flushDecode;

	logic [armPkg::DataWidth-1:0] pcPlus8E;
	logic [armPkg::DataWidth-1:0] operandAE;
	logic [armPkg::DataWidth-1:0] operandBE;
	logic [armPkg::DataWidth-1:0] storeDataE;
	logic [armPkg::DataWidth-1:0] immE;
	logic useImmE;
	armPkg::aluOpT aluOpE;
	armPkg::instrClassT classE;
	armPkg::condT condE;
	logic setFlagsE;
	logic upE;
	logic regWriteE;
	logic memWriteE;
	logic memReadE;
	logic [armPkg::RegAddrWidth-1:0] destE;

	logic branchTaken;
	logic [armPkg::DataWidth-1:0] branchTarget;
	logic regWriteHzE;
	logic [armPkg::RegAddrWidth-1:0] destHzE;
	logic [armPkg::DataWidth-1:0] aluOutM;
	logic [armPkg::RegAddrWidth-1:0] destM;
	logic regWriteM;
	logic memToRegM;

	logic [armPkg::DataWidth-1:0] aluOutW;
	logic [armPkg::RegAddrWidth-1:0] destW;
	logic regWriteW;
	logic memToRegW;
	logic [armPkg::DataWidth-1:0] resultW;

	// fetch pc, a taken branch wins over a stall
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_pc <= ResetPc;
		end else if (branchTaken) begin
			o_pc <= branchTarget;
		end else if (!stallDecode) begin
			o_pc <= o_pc + 4;
		end
	end

	decodeStage decode_i (
		.clk(clk), .reset(reset), .i_inst(i_inst), .i_pc(o_pc),
		.i_stall(stallDecode), .i_flush(flushDecode),
		.i_rdData1(rdData1), .i_rdData2(rdData2),
		.o_rdAddr1(rdAddr1), .o_rdAddr2(rdAddr2), .o_use1(use1), .o_use2(use2),
		.o_pcPlus8E(pcPlus8E), .o_operandAE(operandAE), .o_operandBE(operandBE),
		.o_storeDataE(storeDataE), .o_immE(immE), .o_useImmE(useImmE),
		.o_aluOpE(aluOpE), .o_classE(classE), .o_condE(condE), .o_setFlagsE(setFlagsE),
		.o_upE(upE), .o_regWriteE(regWriteE), .o_memWriteE(memWriteE),
		.o_memReadE(memReadE), .o_destE(destE)
	);

	registerFile regFile_i (
		.clk(clk), .reset(reset),
		.i_rdAddr1(rdAddr1), .i_rdAddr2(rdAddr2),
		.o_rdData1(rdData1), .o_rdData2(rdData2),
		.i_wrAddr(destW), .i_wrData(resultW), .i_wrEnable(regWriteW)
	);

	executeStage execute_i (
		.clk(clk), .reset(reset),
		.i_pcPlus8E(pcPlus8E), .i_operandAE(operandAE), .i_operandBE(operandBE),
		.i_storeDataE(storeDataE), .i_immE(immE), .i_useImmE(useImmE),
		.i_aluOpE(aluOpE), .i_classE(classE), .i_condE(condE), .i_setFlagsE(setFlagsE),
		.i_upE(upE), .i_regWriteE(regWriteE), .i_memWriteE(memWriteE),
		.i_memReadE(memReadE), .i_destE(destE),
		.o_branchTaken(branchTaken), .o_branchTarget(branchTarget),
		.o_regWriteE(regWriteHzE), .o_destE(destHzE),
		.o_aluOutM(aluOutM), .o_storeDataM(o_writeData), .o_destM(destM),
		.o_regWriteM(regWriteM), .o_memWriteM(o_memWrite), .o_memReadM(o_memRead),
		.o_memToRegM(memToRegM)
	);

	hazardUnit hazard_i (
		.i_rdAddr1(rdAddr1), .i_rdAddr2(rdAddr2), .i_use1(use1), .i_use2(use2),
		.i_destE(destHzE), .i_regWriteE(regWriteHzE),
		.i_destM(destM), .i_regWriteM(regWriteM),
		.i_destW(destW), .i_regWriteW(regWriteW),
		.i_branchTaken(branchTaken),
		.o_stallDecode(stallDecode), .o_flushDecode(flushDecode)
	);

	assign o_memAddr = aluOutM;

	// mem/wb
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW <= aluOutM;
		destW <= destM;
	end

	// load data arrives one cycle after the read, right in writeback
	assign resultW = memToRegW ? i_readData : aluOutW;

endmodule

/* dv/armCoreMemModel.sv */
`timescale 1ns/1ps

module armCoreMemModel #(
	parameter int Words = 64
) (
	input  logic                          clk,
	input  logic                          i_load,
	input  logic [armPkg::DataWidth-1:0]  i_program [Words],
	input  logic [armPkg::DataWidth-1:0]  i_pc,
	output logic [armPkg::DataWidth-1:0]  o_inst,
	input  logic [armPkg::DataWidth-1:0]  i_memAddr,
	input  logic                          i_memWrite,
	input  logic                          i_memRead,
	input  logic [armPkg::DataWidth-1:0]  i_writeData,
	output logic [armPkg::DataWidth-1:0]  o_readData
);

	localparam int IndexWidth = $clog2(Words);

	logic [armPkg::DataWidth-1:0] rom [Words];
	logic [armPkg::DataWidth-1:0] ram [Words];

	// fetch answers in the same cycle
	assign o_inst = rom[i_pc[IndexWidth+1:2]];

	always_ff @(posedge clk) begin
		if (i_load) begin
			rom <= i_program;
			o_readData <= '0;
			// fill carries the byte address so stale reads are easy to spot
			for (int i = 0; i < Words; i++) begin
				ram[i] <= {16'hDA7A, 16'(i * 4)};
			end
		end else begin
			if (i_memWrite) begin
				ram[i_memAddr[IndexWidth+1:2]] <= i_writeData;
			end
			if (i_memRead) begin
				o_readData <= ram[i_memAddr[IndexWidth+1:2]];
			end
		end
	end

endmodule

/* dv/armCore_assertions.sv */
`timescale 1ns/1ps

module armCoreAssertions (
	input logic                          clk,
	input logic                          reset,
	input logic [armPkg::DataWidth-1:0]  i_pc,
	input logic                          i_memWrite,
	input logic                          i_memRead
);

	// one access per cycle on the data port
	assert property (@(posedge clk) disable iff (reset) !(i_memWrite && i_memRead))
		else $error("data port drives read and write in the same cycle");

	assert property (@(posedge clk) disable iff (reset) i_pc[1:0] == 2'b00)
		else $error("fetch address is not word aligned");

	assert property (@(posedge clk) reset |-> !i_memWrite)
		else $error("memory write is active while the core is in reset");

endmodule

bind armCore armCoreAssertions assertions_i (
	.clk(clk),
	.reset(reset),
	.i_pc(o_pc),
	.i_memWrite(o_memWrite),
	.i_memRead(o_memRead)
);

/* dv/armCoreTb.sv */
`timescale 1ns/1ps

module armCoreTb;

	localparam int Dw = armPkg::DataWidth;
	localparam logic [Dw-1:0] ResetPc = 32'h0000_0040;
	localparam int MemWords = 64;
	localparam int ProgWords = 16;
	localparam int NumTests = 5;
	localparam int ResetCycles = 8;
	localparam int StoreTimeout = 200;

	logic clk;
	logic reset;
	logic loadProgram;
	logic [Dw-1:0] pc;
	logic [Dw-1:0] inst;
	logic [Dw-1:0] memAddr;
	logic memWrite;
	logic memRead;
	logic [Dw-1:0] writeData;
	logic [Dw-1:0] readData;
	logic [Dw-1:0] programImage [MemWords];

	string testName [NumTests];
	logic [Dw-1:0] programTable [NumTests][ProgWords];
	logic [Dw-1:0] expAddr [NumTests];
	logic [Dw-1:0] expData [NumTests];
	// index of the checked store within the run
	int storeIndex [NumTests];

	armCore #(.ResetPc(ResetPc)) dut_i (
		.clk(clk), .reset(reset), .o_pc(pc), .i_inst(inst),
		.o_memAddr(memAddr), .o_memWrite(memWrite), .o_memRead(memRead),
		.o_writeData(writeData), .i_readData(readData)
	);

	armCoreMemModel #(.Words(MemWords)) mem_i (
		.clk(clk), .i_load(loadProgram), .i_program(programImage),
		.i_pc(pc), .o_inst(inst),
		.i_memAddr(memAddr), .i_memWrite(memWrite), .i_memRead(memRead),
		.i_writeData(writeData), .o_readData(readData)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [Dw-1:0] encodeDataImm(armPkg::condT cond, armPkg::aluOpT op,
		logic s, int rd, int rn, int imm);
		return {cond, 2'b00, 1'b1, op, s, rn[3:0], rd[3:0], 4'h0, imm[7:0]};
	endfunction

	function automatic logic [Dw-1:0] encodeDataReg(armPkg::condT cond, armPkg::aluOpT op,
		logic s, int rd, int rn, int rm);
		return {cond, 2'b00, 1'b0, op, s, rn[3:0], rd[3:0], 8'h00, rm[3:0]};
	endfunction

	// P set, no writeback, word access
	function automatic logic [Dw-1:0] encodeMem(logic load, logic up, int rd, int rn, int offset);
		return {armPkg::condAl, 2'b01, 1'b0, 1'b1, up, 1'b0, 1'b0, load,
			rn[3:0], rd[3:0], offset[11:0]};
	endfunction

	function automatic logic [Dw-1:0] encodeBranch(armPkg::condT cond, int offset);
		return {cond, 3'b101, 1'b0, offset[23:0]};
	endfunction

	task automatic buildTable();
		for (int t = 0; t < NumTests; t++) begin
			for (int j = 0; j < ProgWords; j++) begin
				programTable[t][j] = '0;
			end
			storeIndex[t] = 0;
		end
		// 0x35, 0x45, 0x10, 0xb3, 0xb3 & 0x45 = 0x01, 0x01 + 0xb3 = 0xb4
		testName[0] = "dependent arithmetic";
		programTable[0][0] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 1, 0, 'h35);
		programTable[0][1] = encodeDataImm(armPkg::condAl, armPkg::opAdd, 1'b0, 2, 1, 'h10);
		programTable[0][2] = encodeDataReg(armPkg::condAl, armPkg::opSub, 1'b0, 3, 2, 1);
		programTable[0][3] = encodeDataImm(armPkg::condAl, armPkg::opOrr, 1'b0, 4, 3, 'ha3);
		programTable[0][4] = encodeDataReg(armPkg::condAl, armPkg::opAnd, 1'b0, 5, 4, 2);
		programTable[0][5] = encodeDataReg(armPkg::condAl, armPkg::opAdd, 1'b0, 6, 5, 4);
		programTable[0][6] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 7, 0, 'h80);
		programTable[0][7] = encodeMem(1'b0, 1'b1, 6, 7, 4);
		programTable[0][8] = encodeBranch(armPkg::condAl, -2);
		expAddr[0] = 32'h84;
		expData[0] = 32'hb4;
		// 5 - 5 sets Z and 5 - 9 sets only N so EQ and LT add
		testName[1] = "flags and conditions";
		programTable[1][0] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 1, 0, 5);
		programTable[1][1] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 2, 0, 5);
		programTable[1][2] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 3, 0, 0);
		programTable[1][3] = encodeDataReg(armPkg::condAl, armPkg::opCmp, 1'b1, 0, 1, 2);
		programTable[1][4] = encodeDataImm(armPkg::condEq, armPkg::opAdd, 1'b0, 3, 3, 'h01);
		programTable[1][5] = encodeDataImm(armPkg::condNe, armPkg::opAdd, 1'b0, 3, 3, 'h02);
		programTable[1][6] = encodeDataImm(armPkg::condAl, armPkg::opCmp, 1'b1, 0, 1, 9);
		programTable[1][7] = encodeDataImm(armPkg::condGe, armPkg::opAdd, 1'b0, 3, 3, 'h10);
		programTable[1][8] = encodeDataImm(armPkg::condLt, armPkg::opAdd, 1'b0, 3, 3, 'h20);
		programTable[1][9] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 4, 0, 'h90);
		programTable[1][10] = encodeMem(1'b0, 1'b1, 3, 4, 0);
		programTable[1][11] = encodeBranch(armPkg::condAl, -2);
		expAddr[1] = 32'h90;
		expData[1] = 32'h21;
		// both loads hit 0xa8 and the sum goes to 0xb0 - 4
		testName[2] = "load and store";
		programTable[2][0] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 1, 0, 'h3c);
		programTable[2][1] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 2, 0, 'ha0);
		programTable[2][2] = encodeMem(1'b0, 1'b1, 1, 2, 8);
		programTable[2][3] = encodeMem(1'b1, 1'b1, 3, 2, 8);
		programTable[2][4] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 5, 0, 'hb0);
		programTable[2][5] = encodeMem(1'b1, 1'b0, 4, 5, 8);
		programTable[2][6] = encodeDataReg(armPkg::condAl, armPkg::opAdd, 1'b0, 6, 3, 4);
		programTable[2][7] = encodeMem(1'b0, 1'b0, 6, 5, 4);
		programTable[2][8] = encodeBranch(armPkg::condAl, -2);
		expAddr[2] = 32'hac;
		expData[2] = 32'h78;
		storeIndex[2] = 1;
		// B skips two corrupting adds and BNE falls through into 7 + 3 + 0x10
		testName[3] = "branches";
		programTable[3][0] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 1, 0, 7);
		programTable[3][1] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 2, 0, 7);
		programTable[3][2] = encodeBranch(armPkg::condAl, 1);
		programTable[3][3] = encodeDataImm(armPkg::condAl, armPkg::opAdd, 1'b0, 1, 1, 'h40);
		programTable[3][4] = encodeDataImm(armPkg::condAl, armPkg::opAdd, 1'b0, 1, 1, 'h80);
		programTable[3][5] = encodeDataReg(armPkg::condAl, armPkg::opCmp, 1'b1, 0, 1, 2);
		programTable[3][6] = encodeBranch(armPkg::condNe, 1);
		programTable[3][7] = encodeDataImm(armPkg::condAl, armPkg::opAdd, 1'b0, 1, 1, 3);
		programTable[3][8] = encodeDataImm(armPkg::condAl, armPkg::opAdd, 1'b0, 1, 1, 'h10);
		programTable[3][9] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 3, 0, 'hc0);
		programTable[3][10] = encodeMem(1'b0, 1'b1, 1, 3, 0);
		programTable[3][11] = encodeBranch(armPkg::condAl, -2);
		expAddr[3] = 32'hc0;
		expData[3] = 32'h1a;
		// r1 still held 0x1a and Z was still set before this reset
		testName[4] = "reset state";
		programTable[4][0] = encodeDataImm(armPkg::condAl, armPkg::opAdd, 1'b0, 1, 1, 'h5a);
		programTable[4][1] = encodeDataImm(armPkg::condEq, armPkg::opAdd, 1'b0, 1, 1, 'h80);
		programTable[4][2] = encodeDataImm(armPkg::condAl, armPkg::opMov, 1'b0, 7, 0, 'hd0);
		programTable[4][3] = encodeMem(1'b0, 1'b1, 1, 7, 0);
		programTable[4][4] = encodeBranch(armPkg::condAl, -2);
		expAddr[4] = 32'hd0;
		expData[4] = 32'h5a;
	endtask

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic compareAddress(string name, logic [Dw-1:0] expected, logic [Dw-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic compareData(string name, logic [Dw-1:0] expected, logic [Dw-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "data mismatch");
		end
	endtask

	// program sits at the reset pc with zeros around it
	task automatic resetAndLoad(int t);
		int base;
		base = ResetPc >> 2;
		reset = 1'b1;
		for (int i = 0; i < MemWords; i++) begin
			programImage[i] = '0;
		end
		for (int j = 0; j < ProgWords; j++) begin
			programImage[base + j] = programTable[t][j];
		end
		loadProgram = 1'b1;
		stepCycle();
		loadProgram = 1'b0;
		for (int i = 1; i < ResetCycles; i++) begin
			stepCycle();
		end
		reset = 1'b0;
	endtask

	task automatic waitForStore(int t);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen <= storeIndex[t]) begin
			if (cycles == StoreTimeout) begin
				$display("No store appeared on the data port within %0d cycles in test %s",
					StoreTimeout, testName[t]);
				$display("Simulation failed");
				$fatal(1, "store timeout");
			end
			stepCycle();
			cycles++;
			if (memWrite) begin
				seen++;
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		loadProgram = 1'b0;
		for (int i = 0; i < MemWords; i++) begin
			programImage[i] = '0;
		end
		buildTable();
		for (int t = 0; t < NumTests; t++) begin
			resetAndLoad(t);
			compareAddress({testName[t], " first fetch"}, ResetPc, pc);
			waitForStore(t);
			compareAddress({testName[t], " store address"}, expAddr[t], memAddr);
			compareData({testName[t], " store data"}, expData[t], writeData);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* build.f */
rtl/armPkg.sv
rtl/registerFile.sv
rtl/hazardUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/armCore.sv
dv/armCoreMemModel.sv
dv/armCore_assertions.sv
dv/armCoreTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# builds and runs the armCore testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module armCoreTb -o armCoreSim &&
./obj_dir/armCoreSim || {
	echo "armCore simulation did not pass"
	exit 1
}
